// File: adder_tree.sv
`default_nettype none

module adder_tree (
    input  logic                                  clock_i,
    input  logic                                  rst_n_i,
    input  logic                                  in_valid_i,
    output logic                                  in_ready_o,
    input  logic signed [pw_pkg::OUT_CH-1:0][pw_pkg::IN_CH-1:0][pw_pkg::SUM_W-1:0] in_terms_i,
    input  logic                                  in_last_i,
    output logic                                  out_valid_o,
    input  logic                                  out_ready_i,
    output logic signed [pw_pkg::OUT_CH-1:0][pw_pkg::SUM_W-1:0] out_sums_o,
    output logic                                  out_last_o
);

    // Node values per level, level 0 being the incoming terms
    // Slots past the live count of a level are held at zero
    logic signed [pw_pkg::SUM_W-1:0] node [pw_pkg::TREE_DEPTH+1][pw_pkg::OUT_CH][pw_pkg::IN_CH];

    // Valid and last travelling beside each registered level
    logic [pw_pkg::TREE_DEPTH-1:0] vld_q;
    logic [pw_pkg::TREE_DEPTH-1:0] lst_q;

    // One enable for every level
    logic stage_en;

    //////////////////////////////
    // Handshake
    //////////////////////////////

    assign out_valid_o = vld_q[pw_pkg::TREE_DEPTH-1];
    assign out_last_o = lst_q[pw_pkg::TREE_DEPTH-1];
    // Advance when the output is free or being taken
    assign stage_en = out_ready_i || !out_valid_o;
    assign in_ready_o = stage_en;

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            vld_q <= '0;
        end else if (stage_en) begin
            vld_q <= {vld_q[pw_pkg::TREE_DEPTH-2:0], in_valid_i};
        end
    end

    always_ff @(posedge clock_i) begin
        if (stage_en) begin
            lst_q <= {lst_q[pw_pkg::TREE_DEPTH-2:0], in_last_i};
        end
    end

    //////////////////////////////
    // Reduction levels
    //////////////////////////////

    // Leaves straight from the input terms
    for (genvar o = 0; o < pw_pkg::OUT_CH; o++) begin : gen_leaf_o
        for (genvar i = 0; i < pw_pkg::IN_CH; i++) begin : gen_leaf_i
            assign node[0][o][i] = in_terms_i[o][i];
        end
    end

    for (genvar l = 0; l < pw_pkg::TREE_DEPTH; l++) begin : gen_level
        // Live nodes entering this level, ceil(IN_CH / 2**l)
        localparam int CNT_IN = (pw_pkg::IN_CH + (1 << l) - 1) >> l;

        for (genvar o = 0; o < pw_pkg::OUT_CH; o++) begin : gen_chan
            for (genvar k = 0; k < pw_pkg::IN_CH; k++) begin : gen_node
                if (2 * k + 1 < CNT_IN) begin : gen_add
                    // Pair of neighbours
                    always_ff @(posedge clock_i) begin
                        if (stage_en) begin
                            node[l+1][o][k] <= node[l][o][2*k] + node[l][o][2*k+1];
                        end
                    end
                end else if (2 * k < CNT_IN) begin : gen_pass
                    // Odd term left over, moves down one level untouched
                    always_ff @(posedge clock_i) begin
                        if (stage_en) begin
                            node[l+1][o][k] <= node[l][o][2*k];
                        end
                    end
                end else begin : gen_idle
                    always_ff @(posedge clock_i) begin
                        if (stage_en) begin
                            node[l+1][o][k] <= '0;
                        end
                    end
                end
            end
        end
    end

    // Root of each channel tree
    for (genvar o = 0; o < pw_pkg::OUT_CH; o++) begin : gen_root
        assign out_sums_o[o] = node[pw_pkg::TREE_DEPTH][o][0];
    end

    // Stalled output beat keeps its payload
    a_out_hold: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        out_valid_o && !out_ready_i |=>
            out_valid_o && $stable(out_sums_o) && $stable(out_last_o));

endmodule

`default_nettype wire

// File: pointwise_convolve.sv
`default_nettype none

module pointwise_convolve (
    input  logic                       clock_i,
    input  logic                       rst_n_i,
    input  logic                       s_valid_i,
    output logic                       s_ready_o,
    input  pw_pkg::pix_in_t            s_pix_i,
    output logic                       m_valid_o,
    input  logic                       m_ready_i,
    output pw_pkg::pix_out_t           m_pix_o,
    input  pw_pkg::weight_mat_t        weights_i,
    input  logic [pw_pkg::SHIFT_W-1:0] shift_i
);

    // Products for every output and input channel pair
    logic signed [pw_pkg::OUT_CH-1:0][pw_pkg::IN_CH-1:0][pw_pkg::SUM_W-1:0] prod_d;
    logic signed [pw_pkg::OUT_CH-1:0][pw_pkg::IN_CH-1:0][pw_pkg::SUM_W-1:0] prod_q;
    logic prod_valid_q;
    logic prod_last_q;

    // Tree side
    logic tree_ready;
    logic signed [pw_pkg::OUT_CH-1:0][pw_pkg::SUM_W-1:0] tree_sums;
    logic tree_last;

    //////////////////////////////
    // Multiply stage
    //////////////////////////////

    // Operands widen to SUM_W with sign before the multiply
    for (genvar o = 0; o < pw_pkg::OUT_CH; o++) begin : gen_mul_o
        for (genvar i = 0; i < pw_pkg::IN_CH; i++) begin : gen_mul_i
            assign prod_d[o][i] = $signed(s_pix_i.data[i])
                                * $signed(weights_i[o * pw_pkg::IN_CH + i]);
        end
    end

    // First pipeline stage, moves with the tree
    assign s_ready_o = tree_ready;

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            prod_valid_q <= 1'b0;
        end else if (tree_ready) begin
            prod_valid_q <= s_valid_i;
        end
    end

    always_ff @(posedge clock_i) begin
        if (tree_ready) begin
            prod_q <= prod_d;
            prod_last_q <= s_pix_i.last;
        end
    end

    adder_tree u_tree (
        .clock_i    (clock_i),
        .rst_n_i    (rst_n_i),
        .in_valid_i (prod_valid_q),
        .in_ready_o (tree_ready),
        .in_terms_i (prod_q),
        .in_last_i  (prod_last_q),
        .out_valid_o(m_valid_o),
        .out_ready_i(m_ready_i),
        .out_sums_o (tree_sums),
        .out_last_o (tree_last)
    );

    //////////////////////////////
    // Requantize
    //////////////////////////////

    // Arithmetic shift, then keep the low activation bits
    always_comb begin
        logic signed [pw_pkg::SUM_W-1:0] shifted;
        for (int o = 0; o < pw_pkg::OUT_CH; o++) begin
            shifted = $signed(tree_sums[o]) >>> shift_i;
            m_pix_o.data[o] = shifted[pw_pkg::ACT_W-1:0];
        end
        m_pix_o.last = tree_last;
    end

    // Free-flowing output gives the fixed latency
    a_latency: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        (s_valid_i && s_ready_o) ##1 m_ready_i [* pw_pkg::PIPE_LAT-1] |=> m_valid_o);

endmodule

`default_nettype wire

// File: pw_conv_top.sv
`default_nettype none

module pw_conv_top (
    input  logic                clock_i,
    input  logic                rst_n_i,

    // Register port
    input  pw_pkg::axil_req_t   axil_req_i,
    output pw_pkg::axil_rsp_t   axil_rsp_o,

    // Pixel in
    input  logic                s_valid_i,
    output logic                s_ready_o,
    input  pw_pkg::pix_in_t     s_pix_i,

    // Pixel out
    output logic                m_valid_o,
    input  logic                m_ready_i,
    output pw_pkg::pix_out_t    m_pix_o
);

    //////////////////////////////
    // Configuration
    //////////////////////////////

    // Weight matrix and shift, static while pixels flow
    pw_pkg::weight_mat_t weights;
    logic [pw_pkg::SHIFT_W-1:0] shift;

    weight_regs u_regs (
        .clock_i   (clock_i),
        .rst_n_i   (rst_n_i),
        .axil_req_i(axil_req_i),
        .axil_rsp_o(axil_rsp_o),
        .weights_o (weights),
        .shift_o   (shift)
    );

    //////////////////////////////
    // Datapath
    //////////////////////////////

    pointwise_convolve u_conv (
        .clock_i  (clock_i),
        .rst_n_i  (rst_n_i),
        .s_valid_i(s_valid_i),
        .s_ready_o(s_ready_o),
        .s_pix_i  (s_pix_i),
        .m_valid_o(m_valid_o),
        .m_ready_i(m_ready_i),
        .m_pix_o  (m_pix_o),
        .weights_i(weights),
        .shift_i  (shift)
    );

endmodule

`default_nettype wire

// File: pw_pkg.sv
`default_nettype none

package pw_pkg;

    //////////////////////////////
    // Datapath sizes
    //////////////////////////////

    // Activation and weight widths
    localparam int ACT_W = 8;
    localparam int WGT_W = 8;
    localparam int IN_CH = 3;
    localparam int OUT_CH = 3;
    // Product width plus two guard bits for the channel sum
    localparam int SUM_W = ACT_W + WGT_W + 2;
    // Two pairwise levels reduce three terms to one
    localparam int TREE_DEPTH = 2;
    // Product register plus the adder levels
    localparam int PIPE_LAT = 3;
    localparam int SHIFT_W = 4;

    //////////////////////////////
    // Register map
    //////////////////////////////

    localparam int ADDR_W = 8;
    localparam int AXIL_DW = 32;
    localparam int NUM_WEIGHTS = OUT_CH * IN_CH;
    // One weight per word, output-major order
    localparam logic [ADDR_W-1:0] WEIGHT_BASE = 8'h00;
    localparam logic [ADDR_W-1:0] SHIFT_ADDR = 8'h24;
    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    //////////////////////////////
    // Types
    //////////////////////////////

    // Input pixel, lane 0 in the low bits
    typedef struct packed {
        logic signed [IN_CH-1:0][ACT_W-1:0] data;
        logic last;
    } pix_in_t;

    // Output pixel after shift and truncation
    typedef struct packed {
        logic [OUT_CH-1:0][ACT_W-1:0] data;
        logic last;
    } pix_out_t;

    // Entry o*IN_CH+i is the weight from input i to output o
    typedef logic signed [NUM_WEIGHTS-1:0][WGT_W-1:0] weight_mat_t;

    // Master side of the AXI4-Lite port
    typedef struct packed {
        logic awvalid;
        logic [ADDR_W-1:0] awaddr;
        logic wvalid;
        logic [AXIL_DW-1:0] wdata;
        logic [AXIL_DW/8-1:0] wstrb;
        logic bready;
        logic arvalid;
        logic [ADDR_W-1:0] araddr;
        logic rready;
    } axil_req_t;

    // Slave side of the AXI4-Lite port
    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
        logic [1:0] bresp;
        logic arready;
        logic rvalid;
        logic [AXIL_DW-1:0] rdata;
        logic [1:0] rresp;
    } axil_rsp_t;

    // Write channel state
    typedef enum logic {
        WR_IDLE,
        WR_RESP
    } axil_state_e;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the pointwise convolution testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pw_conv -f vlog.f -o sim_pw_conv

./obj_dir/sim_pw_conv > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi

// File: tb_pw_conv.sv
`default_nettype none

module tb_pw_conv;

    localparam int NUM_PIX = 200;
    // Ten reads after reset, ten writes, ten reads, one bad write, one bad read, ten reads
    localparam int NUM_ACC = 42;
    localparam int WATCHDOG_CYCLES = NUM_PIX * 4 + NUM_ACC * 10 + 200;
    localparam logic [pw_pkg::ADDR_W-1:0] BAD_ADDR = 8'h40;

    logic clock_i;
    logic rst_n_i;
    pw_pkg::axil_req_t axil_req_i;
    pw_pkg::axil_rsp_t axil_rsp_o;
    logic s_valid_i;
    logic s_ready_o;
    pw_pkg::pix_in_t s_pix_i;
    logic m_valid_o;
    logic m_ready_i;
    pw_pkg::pix_out_t m_pix_o;

    // Reference register contents and expected responses
    logic signed [pw_pkg::WGT_W-1:0] exp_wgt [pw_pkg::NUM_WEIGHTS];
    logic [pw_pkg::SHIFT_W-1:0] exp_shift;
    logic [1:0] exp_bresp;
    logic [1:0] exp_rresp;
    logic [31:0] exp_rdata;

    // Scoreboard
    pw_pkg::pix_out_t sb_q [$];
    pw_pkg::pix_out_t exp_head;
    pw_pkg::pix_out_t held_pix;
    logic sb_empty;
    int in_count;
    int out_count;
    logic done;
    int value_errors;
    int protocol_errors;
    logic [31:0] lfsr_state = 32'h48d40f45;

    pw_conv_top u_dut (
        .clock_i   (clock_i),
        .rst_n_i   (rst_n_i),
        .axil_req_i(axil_req_i),
        .axil_rsp_o(axil_rsp_o),
        .s_valid_i (s_valid_i),
        .s_ready_o (s_ready_o),
        .s_pix_i   (s_pix_i),
        .m_valid_o (m_valid_o),
        .m_ready_i (m_ready_i),
        .m_pix_o   (m_pix_o)
    );

    initial begin
        clock_i = 1'b0;
        forever #10 clock_i = ~clock_i;
    end

    //////////////////////////////
    // Random source and reference model
    //////////////////////////////

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    // Weight index for a mapped word, NUM_WEIGHTS for the shift, -1 when unmapped
    function automatic int reg_index(input logic [pw_pkg::ADDR_W-1:0] addr);
        int offs;
        offs = int'(addr) - int'(pw_pkg::WEIGHT_BASE);
        if (offs >= 0 && offs < 4 * pw_pkg::NUM_WEIGHTS) begin
            return offs / 4;
        end
        if (addr[pw_pkg::ADDR_W-1:2] == pw_pkg::SHIFT_ADDR[pw_pkg::ADDR_W-1:2]) begin
            return pw_pkg::NUM_WEIGHTS;
        end
        return -1;
    endfunction

    function automatic pw_pkg::pix_in_t random_pixel(input int idx);
        pw_pkg::pix_in_t pix;
        logic [31:0] rnd;
        for (int i = 0; i < pw_pkg::IN_CH; i++) begin
            rnd = lfsr_bits(pw_pkg::ACT_W);
            pix.data[i] = rnd[pw_pkg::ACT_W-1:0];
        end
        // Every eighth pixel closes a line
        pix.last = (idx % 8) == 7;
        return pix;
    endfunction

    // Dot product per output, arithmetic shift, low activation bits kept
    function automatic pw_pkg::pix_out_t expected_pixel(input pw_pkg::pix_in_t pix);
        pw_pkg::pix_out_t res;
        int acc;
        for (int o = 0; o < pw_pkg::OUT_CH; o++) begin
            acc = 0;
            for (int i = 0; i < pw_pkg::IN_CH; i++) begin
                acc += int'($signed(pix.data[i])) * int'(exp_wgt[o * pw_pkg::IN_CH + i]);
            end
            acc = acc >>> exp_shift;
            res.data[o] = acc[pw_pkg::ACT_W-1:0];
        end
        res.last = pix.last;
        return res;
    endfunction

    // Register model follows accepted writes and reads
    always @(posedge clock_i) begin
        int idx;
        if (!rst_n_i) begin
            foreach (exp_wgt[k]) exp_wgt[k] <= '0;
            exp_shift <= '0;
        end else begin
            if (axil_req_i.awvalid && axil_rsp_o.awready) begin
                idx = reg_index(axil_req_i.awaddr);
                exp_bresp <= (idx < 0) ? pw_pkg::RESP_SLVERR : pw_pkg::RESP_OKAY;
                if (idx == pw_pkg::NUM_WEIGHTS) begin
                    exp_shift <= axil_req_i.wdata[pw_pkg::SHIFT_W-1:0];
                end else if (idx >= 0) begin
                    exp_wgt[idx] <= axil_req_i.wdata[pw_pkg::WGT_W-1:0];
                end
            end
            if (axil_req_i.arvalid && axil_rsp_o.arready) begin
                idx = reg_index(axil_req_i.araddr);
                exp_rresp <= (idx < 0) ? pw_pkg::RESP_SLVERR : pw_pkg::RESP_OKAY;
                if (idx == pw_pkg::NUM_WEIGHTS) begin
                    exp_rdata <= {{(32 - pw_pkg::SHIFT_W){1'b0}}, exp_shift};
                end else if (idx >= 0) begin
                    exp_rdata <= {{(32 - pw_pkg::WGT_W){exp_wgt[idx][pw_pkg::WGT_W-1]}},
                                  exp_wgt[idx]};
                end else begin
                    exp_rdata <= '0;
                end
            end
        end
    end

    // Expected pixel queued on acceptance, retired on output
    always @(posedge clock_i) begin
        held_pix <= m_pix_o;
        if (!rst_n_i) begin
            sb_q.delete();
            in_count <= 0;
            out_count <= 0;
        end else begin
            if (m_valid_o && m_ready_i) begin
                if (sb_q.size() != 0) begin
                    void'(sb_q.pop_front());
                end
                out_count <= out_count + 1;
            end
            if (s_valid_i && s_ready_o) begin
                sb_q.push_back(expected_pixel(s_pix_i));
                in_count <= in_count + 1;
            end
        end
        sb_empty = sb_q.size() == 0;
        exp_head = sb_empty ? '0 : sb_q[0];
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    a_reset_idle: assert property (@(posedge clock_i) $rose(rst_n_i) |->
        !m_valid_o && !axil_rsp_o.bvalid && !axil_rsp_o.rvalid)
        else begin
            protocol_errors++;
            $display("Output valid or response valid was high right after reset");
        end

    a_bresp: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        axil_rsp_o.bvalid && axil_req_i.bready |-> axil_rsp_o.bresp == exp_bresp)
        else begin
            value_errors++;
            $display("FAILED %0t bresp expected %h got %h", $time,
                     $sampled(exp_bresp), $sampled(axil_rsp_o.bresp));
        end

    a_rresp: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        axil_rsp_o.rvalid && axil_req_i.rready |-> axil_rsp_o.rresp == exp_rresp)
        else begin
            value_errors++;
            $display("FAILED %0t rresp expected %h got %h", $time,
                     $sampled(exp_rresp), $sampled(axil_rsp_o.rresp));
        end

    // Data only matters for a mapped register
    a_rdata: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        axil_rsp_o.rvalid && axil_req_i.rready && exp_rresp == pw_pkg::RESP_OKAY |->
            axil_rsp_o.rdata == exp_rdata)
        else begin
            value_errors++;
            $display("FAILED %0t rdata expected %h got %h", $time,
                     $sampled(exp_rdata), $sampled(axil_rsp_o.rdata));
        end

    a_pix: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        m_valid_o && m_ready_i && !sb_empty |-> m_pix_o == exp_head)
        else begin
            value_errors++;
            $display("FAILED %0t m_pix_o expected %h got %h", $time,
                     $sampled(exp_head), $sampled(m_pix_o));
        end

    a_no_extra: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        m_valid_o && m_ready_i |-> !sb_empty)
        else begin
            protocol_errors++;
            $display("An output pixel arrived with no input pixel pending");
        end

    a_latency: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        (s_valid_i && s_ready_o) ##1 m_ready_i [* pw_pkg::PIPE_LAT-1] |=> m_valid_o)
        else begin
            protocol_errors++;
            $display("An accepted pixel did not reach the output on time at %0t", $time);
        end

    a_valid_hold: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        m_valid_o && !m_ready_i |=> m_valid_o)
        else begin
            protocol_errors++;
            $display("Output valid dropped before the pixel was taken at %0t", $time);
        end

    a_pix_hold: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        m_valid_o && !m_ready_i |=> m_pix_o == held_pix)
        else begin
            value_errors++;
            $display("FAILED %0t m_pix_o expected %h got %h", $time,
                     $sampled(held_pix), $sampled(m_pix_o));
        end

    a_count: assert property (@(posedge clock_i) done |-> out_count == in_count)
        else begin
            value_errors++;
            $display("FAILED %0t out_count expected %0d got %0d", $time,
                     $sampled(in_count), $sampled(out_count));
        end

    a_drained: assert property (@(posedge clock_i) done |-> sb_empty)
        else begin
            protocol_errors++;
            $display("Expected pixels were still queued at the end of the run");
        end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic reg_write(input logic [pw_pkg::ADDR_W-1:0] addr, input logic [31:0] data);
        @(negedge clock_i);
        axil_req_i.awvalid = 1'b1;
        axil_req_i.awaddr = addr;
        axil_req_i.wvalid = 1'b1;
        axil_req_i.wdata = data;
        // Address and data go in together, then the response shows up
        do begin
            @(negedge clock_i);
        end while (!axil_rsp_o.bvalid);
        axil_req_i.awvalid = 1'b0;
        axil_req_i.wvalid = 1'b0;
        axil_req_i.bready = 1'b1;
        @(negedge clock_i);
        axil_req_i.bready = 1'b0;
    endtask

    task automatic reg_read(input logic [pw_pkg::ADDR_W-1:0] addr);
        @(negedge clock_i);
        axil_req_i.arvalid = 1'b1;
        axil_req_i.araddr = addr;
        do begin
            @(negedge clock_i);
        end while (!axil_rsp_o.rvalid);
        axil_req_i.arvalid = 1'b0;
        axil_req_i.rready = 1'b1;
        @(negedge clock_i);
        axil_req_i.rready = 1'b0;
    endtask

    task automatic read_all();
        logic [pw_pkg::ADDR_W-1:0] addr;
        addr = pw_pkg::WEIGHT_BASE;
        for (int k = 0; k < pw_pkg::NUM_WEIGHTS; k++) begin
            reg_read(addr);
            addr += 4;
        end
        reg_read(pw_pkg::SHIFT_ADDR);
    endtask

    // Full random words, so the upper bits must be dropped by the DUT
    task automatic program_regs();
        logic [pw_pkg::ADDR_W-1:0] addr;
        logic [31:0] rnd;
        addr = pw_pkg::WEIGHT_BASE;
        for (int k = 0; k < pw_pkg::NUM_WEIGHTS; k++) begin
            reg_write(addr, lfsr_bits(32));
            addr += 4;
        end
        rnd = lfsr_bits(32);
        // Shift of 3 to 6 keeps outputs in a useful range
        rnd[pw_pkg::SHIFT_W-1:0] = 4'd3 + rnd[1:0];
        reg_write(pw_pkg::SHIFT_ADDR, rnd);
    endtask

    task automatic stream_pixels(input int count, input logic random_ready);
        int stop;
        int cur_idx;
        stop = in_count + count;
        @(negedge clock_i);
        cur_idx = in_count;
        s_valid_i = 1'b1;
        s_pix_i = random_pixel(cur_idx);
        m_ready_i = random_ready ? lfsr_bits(1) != 0 : 1'b1;
        while (in_count < stop) begin
            @(negedge clock_i);
            if (random_ready) begin
                m_ready_i = lfsr_bits(1) != 0;
            end
            // New pixel only once the held one was taken
            if (in_count != cur_idx && in_count < stop) begin
                cur_idx = in_count;
                s_pix_i = random_pixel(cur_idx);
            end
        end
        s_valid_i = 1'b0;
    endtask

    initial begin
        rst_n_i = 1'b0;
        axil_req_i = '0;
        axil_req_i.wstrb = 4'hF;
        s_valid_i = 1'b0;
        s_pix_i = '0;
        m_ready_i = 1'b1;
        done = 1'b0;
        value_errors = 0;
        protocol_errors = 0;
        repeat (10) @(posedge clock_i);
        @(negedge clock_i);
        rst_n_i = 1'b1;

        read_all();
        program_regs();
        read_all();
        reg_write(BAD_ADDR, 32'hFFFF_FFFF);
        reg_read(BAD_ADDR);
        read_all();

        stream_pixels(NUM_PIX / 2, 1'b0);
        stream_pixels(NUM_PIX / 2, 1'b1);
        m_ready_i = 1'b1;
        for (int k = 0; k < 4 * pw_pkg::PIPE_LAT && out_count != in_count; k++) begin
            @(negedge clock_i);
        end
        done = 1'b1;
        @(negedge clock_i);

        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock_i);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
pw_pkg.sv
weight_regs.sv
adder_tree.sv
pointwise_convolve.sv
pw_conv_top.sv
tb_pw_conv.sv

// File: weight_regs.sv
`default_nettype none

module weight_regs (
    input  logic                       clock_i,
    input  logic                       rst_n_i,
    input  pw_pkg::axil_req_t          axil_req_i,
    output pw_pkg::axil_rsp_t          axil_rsp_o,
    output pw_pkg::weight_mat_t        weights_o,
    output logic [pw_pkg::SHIFT_W-1:0] shift_o
);

    // Register contents
    pw_pkg::weight_mat_t weights_q;
    logic [pw_pkg::SHIFT_W-1:0] shift_q;

    // Write channel
    pw_pkg::axil_state_e wr_state_q;
    logic [1:0] bresp_q;
    logic wr_fire;
    logic wr_en;
    logic [pw_pkg::ADDR_W-3:0] aw_word;
    logic aw_hit_wgt;
    logic aw_hit_shift;

    // Read channel
    logic rvalid_q;
    logic [pw_pkg::AXIL_DW-1:0] rdata_q;
    logic [1:0] rresp_q;
    logic rd_fire;
    logic [pw_pkg::ADDR_W-3:0] ar_word;
    logic ar_hit_wgt;
    logic ar_hit_shift;
    logic signed [pw_pkg::WGT_W-1:0] rd_wgt;
    logic [pw_pkg::AXIL_DW-1:0] rd_data_d;

    //////////////////////////////
    // Address decode
    //////////////////////////////

    // Word offsets from the weight base, byte lanes ignored
    assign aw_word = axil_req_i.awaddr[pw_pkg::ADDR_W-1:2] - pw_pkg::WEIGHT_BASE[pw_pkg::ADDR_W-1:2];
    assign ar_word = axil_req_i.araddr[pw_pkg::ADDR_W-1:2] - pw_pkg::WEIGHT_BASE[pw_pkg::ADDR_W-1:2];

    assign aw_hit_wgt = aw_word < pw_pkg::NUM_WEIGHTS;
    assign ar_hit_wgt = ar_word < pw_pkg::NUM_WEIGHTS;
    assign aw_hit_shift = axil_req_i.awaddr[pw_pkg::ADDR_W-1:2] == pw_pkg::SHIFT_ADDR[pw_pkg::ADDR_W-1:2];
    assign ar_hit_shift = axil_req_i.araddr[pw_pkg::ADDR_W-1:2] == pw_pkg::SHIFT_ADDR[pw_pkg::ADDR_W-1:2];

    //////////////////////////////
    // Write channel
    //////////////////////////////

    // Address and data are taken together, one write at a time
    assign wr_fire = (wr_state_q == pw_pkg::WR_IDLE) && axil_req_i.awvalid && axil_req_i.wvalid;
    // Every register lives in byte lane 0
    assign wr_en = wr_fire && axil_req_i.wstrb[0];

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            wr_state_q <= pw_pkg::WR_IDLE;
            bresp_q <= pw_pkg::RESP_OKAY;
            weights_q <= '0;
            shift_q <= '0;
        end else begin
            case (wr_state_q)
                pw_pkg::WR_IDLE: begin
                    if (wr_fire) begin
                        wr_state_q <= pw_pkg::WR_RESP;
                        // Unmapped address answers with an error and stores nothing
                        bresp_q <= (aw_hit_wgt || aw_hit_shift) ? pw_pkg::RESP_OKAY
                                                                : pw_pkg::RESP_SLVERR;
                    end
                    if (wr_en && aw_hit_wgt) begin
                        weights_q[aw_word] <= axil_req_i.wdata[pw_pkg::WGT_W-1:0];
                    end
                    if (wr_en && aw_hit_shift) begin
                        shift_q <= axil_req_i.wdata[pw_pkg::SHIFT_W-1:0];
                    end
                end
                pw_pkg::WR_RESP: begin
                    if (axil_req_i.bready) begin
                        wr_state_q <= pw_pkg::WR_IDLE;
                    end
                end
                default: wr_state_q <= pw_pkg::WR_IDLE;
            endcase
        end
    end

    //////////////////////////////
    // Read channel
    //////////////////////////////

    // New address only once the previous response is gone
    assign rd_fire = axil_req_i.arvalid && !rvalid_q;

    // Weight sign-extends through the signed temporary, shift zero-extends
    always_comb begin
        rd_wgt = weights_q[ar_word];
        rd_data_d = '0;
        if (ar_hit_wgt) begin
            rd_data_d = rd_wgt;
        end else if (ar_hit_shift) begin
            rd_data_d = shift_q;
        end
    end

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
        end else if (rd_fire) begin
            rvalid_q <= 1'b1;
        end else if (axil_req_i.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock_i) begin
        if (rd_fire) begin
            rdata_q <= rd_data_d;
            rresp_q <= (ar_hit_wgt || ar_hit_shift) ? pw_pkg::RESP_OKAY : pw_pkg::RESP_SLVERR;
        end
    end

    always_comb begin
        axil_rsp_o.awready = wr_fire;
        axil_rsp_o.wready = wr_fire;
        axil_rsp_o.bvalid = wr_state_q == pw_pkg::WR_RESP;
        axil_rsp_o.bresp = bresp_q;
        axil_rsp_o.arready = !rvalid_q;
        axil_rsp_o.rvalid = rvalid_q;
        axil_rsp_o.rdata = rdata_q;
        axil_rsp_o.rresp = rresp_q;
    end

    assign weights_o = weights_q;
    assign shift_o = shift_q;

    // Write response waits for the master
    a_bvalid_hold: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        axil_rsp_o.bvalid && !axil_req_i.bready |=> axil_rsp_o.bvalid);

    // Read data frozen until accepted
    a_rdata_hold: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        axil_rsp_o.rvalid && !axil_req_i.rready |=>
            axil_rsp_o.rvalid && $stable(axil_rsp_o.rdata));

endmodule

`default_nettype wire
